/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_top
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/line_mem.sv */
`timescale 1ns/1ps

module line_mem #(
    parameter int read_latency  = 2,
    parameter int mem_tag_width = 6
) (
    input  logic clk,
    input  logic reset,

    input  logic                                req_valid,
    input  logic                                req_write,
    input  logic [mem_port_pkg::addr_width-1:0] req_addr,
    input  logic [mem_port_pkg::line_width-1:0] req_data,
    input  logic [mem_tag_width-1:0]            req_tag,
    output logic                                req_ready,

    output logic                                rsp_valid,
    output logic [mem_port_pkg::line_width-1:0] rsp_data,
    output logic [mem_tag_width-1:0]            rsp_tag,
    input  logic                                rsp_ready
);

    localparam int depth = 1 << mem_port_pkg::addr_width;

    logic [mem_port_pkg::line_width-1:0] storage [depth];

    logic [read_latency-1:0]                                 stage_valid;
    logic [read_latency-1:0][mem_port_pkg::line_width-1:0]   stage_data;
    logic [read_latency-1:0][mem_tag_width-1:0]              stage_tag;

    logic stall;
    logic accept;

    assign stall     = rsp_valid && !rsp_ready;  // Held output freezes every stage.
    assign req_ready = !stall;
    assign accept    = req_valid && req_ready;

    assign rsp_valid = stage_valid[read_latency-1];
    assign rsp_data  = stage_data[read_latency-1];
    assign rsp_tag   = stage_tag[read_latency-1];

    always_ff @(posedge clk) begin
        if (accept && req_write)
            storage[req_addr] <= req_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid[0] <= accept && !req_write;
            for (int s = 1; s < read_latency; s++)
                stage_valid[s] <= stage_valid[s-1];
        end
    end

    // Payload stages follow the valid bits.
    always_ff @(posedge clk) begin
        if (!stall) begin
            stage_data[0] <= storage[req_addr];
            stage_tag[0]  <= req_tag;
            for (int s = 1; s < read_latency; s++) begin
                stage_data[s] <= stage_data[s-1];
                stage_tag[s]  <= stage_tag[s-1];
            end
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data) && $stable(rsp_tag)));

endmodule

/* source/mem_arb.sv */
`timescale 1ns/1ps

module mem_arb #(
    parameter int num_requests = 4
) (
    input  logic clk,
    input  logic reset,

    // Request queues.
    input  logic [num_requests-1:0]                                   q_valid,
    input  logic [num_requests-1:0]                                   q_write,
    input  logic [num_requests-1:0][mem_port_pkg::addr_width-1:0]     q_addr,
    input  logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     q_data,
    input  logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] q_tag,
    output logic [num_requests-1:0]                                   q_ready,

    // Line memory request.
    output logic                                   mem_req_valid,
    output logic                                   mem_req_write,
    output logic [mem_port_pkg::addr_width-1:0]    mem_req_addr,
    output logic [mem_port_pkg::line_width-1:0]    mem_req_data,
    output logic [mem_port_pkg::mem_tag_width-1:0] mem_req_tag,
    input  logic                                   mem_req_ready,

    // Line memory response.
    input  logic                                   mem_rsp_valid,
    input  logic [mem_port_pkg::line_width-1:0]    mem_rsp_data,
    input  logic [mem_port_pkg::mem_tag_width-1:0] mem_rsp_tag,
    output logic                                   mem_rsp_ready,

    // Response queues.
    output logic [num_requests-1:0]                                   rq_valid,
    output logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     rq_data,
    output logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] rq_tag,
    input  logic [num_requests-1:0]                                   rq_ready
);

    logic [mem_port_pkg::req_bits-1:0] ptr;
    logic [mem_port_pkg::req_bits-1:0] sel;
    logic [num_requests-1:0]           grant;
    logic [mem_port_pkg::req_bits-1:0] rsp_sel;

    // First valid queue at or after the pointer wins.
    always_comb begin
        int idx;
        logic found;
        grant = '0;
        sel   = '0;
        found = 1'b0;
        for (int k = 0; k < num_requests; k++) begin
            idx = (int'(ptr) + k) % num_requests;
            if (!found && q_valid[idx]) begin
                found      = 1'b1;
                grant[idx] = 1'b1;
                sel        = mem_port_pkg::req_bits'(idx);
            end
        end
    end

    assign mem_req_valid = |q_valid;
    assign mem_req_write = q_write[sel];
    assign mem_req_addr  = q_addr[sel];
    assign mem_req_data  = q_data[sel];
    assign mem_req_tag   = {q_tag[sel], sel};  // Requester number in the low bits.
    assign q_ready       = grant & {num_requests{mem_req_ready}};

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (mem_req_valid && mem_req_ready) begin
            if (int'(sel) == num_requests - 1)
                ptr <= '0;
            else
                ptr <= sel + 1'b1;
        end
    end

    assign rsp_sel = mem_rsp_tag[mem_port_pkg::req_bits-1:0];

    for (genvar i = 0; i < num_requests; i++) begin : g_route
        assign rq_valid[i] = mem_rsp_valid && (int'(rsp_sel) == i);
        assign rq_data[i]  = mem_rsp_data;
        assign rq_tag[i]   = mem_rsp_tag[mem_port_pkg::mem_tag_width-1:mem_port_pkg::req_bits];
    end

    assign mem_rsp_ready = rq_ready[rsp_sel];

    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> $onehot(grant));

    // Tags coming back from memory must name a real requester.
    a_rsp_in_range: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> (int'(rsp_sel) < num_requests));

endmodule

/* source/mem_port_pkg.sv */
package mem_port_pkg;

    parameter int addr_width     = 8;
    parameter int line_width     = 32;
    parameter int core_tag_width = 4;
    parameter int max_requests   = 4;
    parameter int req_bits       = 2;  // Enough for max_requests.
    parameter int mem_tag_width  = core_tag_width + req_bits;

    typedef struct packed {
        logic                      write;
        logic [addr_width-1:0]     addr;
        logic [line_width-1:0]     data;
        logic [core_tag_width-1:0] tag;
    } core_req_t;

    typedef struct packed {
        logic [line_width-1:0]     data;
        logic [core_tag_width-1:0] tag;
    } core_rsp_t;

endpackage

/* source/mem_port_top.sv */
`timescale 1ns/1ps

module mem_port_top #(
    parameter int num_requests = 4,
    parameter int read_latency = 2
) (
    input  logic clk,
    input  logic reset,

    input  logic [num_requests-1:0]                                   core_req_valid,
    input  logic [num_requests-1:0]                                   core_req_write,
    input  logic [num_requests-1:0][mem_port_pkg::addr_width-1:0]     core_req_addr,
    input  logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     core_req_data,
    input  logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] core_req_tag,
    output logic [num_requests-1:0]                                   core_req_ready,

    output logic [num_requests-1:0]                                   core_rsp_valid,
    output logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     core_rsp_data,
    output logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] core_rsp_tag,
    input  logic [num_requests-1:0]                                   core_rsp_ready
);

    mem_port_pkg::core_req_t req_in  [num_requests];
    mem_port_pkg::core_req_t req_out [num_requests];
    mem_port_pkg::core_rsp_t rsp_in  [num_requests];
    mem_port_pkg::core_rsp_t rsp_out [num_requests];

    logic [num_requests-1:0]                                   q_valid;
    logic [num_requests-1:0]                                   q_ready;
    logic [num_requests-1:0]                                   q_write;
    logic [num_requests-1:0][mem_port_pkg::addr_width-1:0]     q_addr;
    logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     q_data;
    logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] q_tag;

    logic [num_requests-1:0]                                   rq_valid;
    logic [num_requests-1:0]                                   rq_ready;
    logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     rq_data;
    logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] rq_tag;

    logic                                   mem_req_valid;
    logic                                   mem_req_ready;
    logic                                   mem_req_write;
    logic [mem_port_pkg::addr_width-1:0]    mem_req_addr;
    logic [mem_port_pkg::line_width-1:0]    mem_req_data;
    logic [mem_port_pkg::mem_tag_width-1:0] mem_req_tag;
    logic                                   mem_rsp_valid;
    logic                                   mem_rsp_ready;
    logic [mem_port_pkg::line_width-1:0]    mem_rsp_data;
    logic [mem_port_pkg::mem_tag_width-1:0] mem_rsp_tag;

    for (genvar i = 0; i < num_requests; i++) begin : g_req
        assign req_in[i].write = core_req_write[i];
        assign req_in[i].addr  = core_req_addr[i];
        assign req_in[i].data  = core_req_data[i];
        assign req_in[i].tag   = core_req_tag[i];

        stream_fifo #(.payload_t(mem_port_pkg::core_req_t)) req_fifo_i (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (core_req_valid[i]),
            .in_data   (req_in[i]),
            .in_ready  (core_req_ready[i]),
            .out_valid (q_valid[i]),
            .out_data  (req_out[i]),
            .out_ready (q_ready[i])
        );

        assign q_write[i] = req_out[i].write;
        assign q_addr[i]  = req_out[i].addr;
        assign q_data[i]  = req_out[i].data;
        assign q_tag[i]   = req_out[i].tag;
    end

    mem_arb #(.num_requests(num_requests)) arb_i (
        .clk           (clk),
        .reset         (reset),
        .q_valid       (q_valid),
        .q_write       (q_write),
        .q_addr        (q_addr),
        .q_data        (q_data),
        .q_tag         (q_tag),
        .q_ready       (q_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_write (mem_req_write),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready),
        .rq_valid      (rq_valid),
        .rq_data       (rq_data),
        .rq_tag        (rq_tag),
        .rq_ready      (rq_ready)
    );

    line_mem #(
        .read_latency  (read_latency),
        .mem_tag_width (mem_port_pkg::mem_tag_width)
    ) mem_i (
        .clk       (clk),
        .reset     (reset),
        .req_valid (mem_req_valid),
        .req_write (mem_req_write),
        .req_addr  (mem_req_addr),
        .req_data  (mem_req_data),
        .req_tag   (mem_req_tag),
        .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp_data  (mem_rsp_data),
        .rsp_tag   (mem_rsp_tag),
        .rsp_ready (mem_rsp_ready)
    );

    for (genvar i = 0; i < num_requests; i++) begin : g_rsp
        assign rsp_in[i].data = rq_data[i];
        assign rsp_in[i].tag  = rq_tag[i];

        stream_fifo #(.payload_t(mem_port_pkg::core_rsp_t)) rsp_fifo_i (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (rq_valid[i]),
            .in_data   (rsp_in[i]),
            .in_ready  (rq_ready[i]),
            .out_valid (core_rsp_valid[i]),
            .out_data  (rsp_out[i]),
            .out_ready (core_rsp_ready[i])
        );

        assign core_rsp_data[i] = rsp_out[i].data;
        assign core_rsp_tag[i]  = rsp_out[i].tag;
    end

endmodule

/* source/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    payload_t   entries [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       wr_en;
    logic       rd_en;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entries[rd_ptr];

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (wr_en)
                wr_ptr <= ~wr_ptr;
            if (rd_en)
                rd_ptr <= ~rd_ptr;
            count <= count + 2'(wr_en) - 2'(rd_en);  // Net occupancy change.
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            entries[wr_ptr] <= in_data;
    end

    // A write lands only in a free entry.
    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (count == 2'd0 || wr_ptr != rd_ptr));

endmodule

/* tb/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
    parameter int num_requests = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic [2:0] phase,

    input  logic [num_requests-1:0]                                   core_req_valid,
    input  logic [num_requests-1:0]                                   core_req_write,
    input  logic [num_requests-1:0][mem_port_pkg::addr_width-1:0]     core_req_addr,
    input  logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     core_req_data,
    input  logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] core_req_tag,
    input  logic [num_requests-1:0]                                   core_req_ready,
    input  logic [num_requests-1:0]                                   core_rsp_valid,
    input  logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     core_rsp_data,
    input  logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] core_rsp_tag,
    input  logic [num_requests-1:0]                                   core_rsp_ready,

    output int error_count,
    output int pending
);

    localparam int entry_width = mem_port_pkg::line_width + mem_port_pkg::core_tag_width;
    localparam int warmup      = 2;  // Request queues still filling before this.

    logic [mem_port_pkg::line_width-1:0] model_mem [1 << mem_port_pkg::addr_width];
    logic [entry_width-1:0] exp_ring [num_requests][64];  // Expected {data, tag}.
    logic [5:0] head [num_requests];
    logic [5:0] tail [num_requests];
    int         own_count [num_requests];
    int         others_since [num_requests];
    int         errors = 0;
    int         phase_errors = 0;
    int         checks = 0;
    logic       reset_d = 1'b0;
    logic [2:0] phase_d = 3'd0;

    assign error_count = errors;

    initial begin
        pending = 0;
        for (int i = 0; i < num_requests; i++) begin
            head[i]         = '0;
            tail[i]         = '0;
            own_count[i]    = 0;
            others_since[i] = 0;
        end
    end

    function automatic string test_name(input logic [2:0] p);
        case (p)
            3'd0: return "reset";
            3'd1: return "single_requester";
            3'd2: return "all_random";
            3'd3: return "back_pressure";
            3'd4: return "fairness";
            default: return "end";
        endcase
    endfunction

    task automatic count_error();
        errors++;
        phase_errors++;
    endtask

    task automatic check_responses();
        logic [mem_port_pkg::line_width-1:0]     exp_data;
        logic [mem_port_pkg::core_tag_width-1:0] exp_tag;
        for (int i = 0; i < num_requests; i++) begin
            if (core_rsp_valid[i] && core_rsp_ready[i]) begin
                if (head[i] == tail[i]) begin
                    $display("Test %s: requester %0d got a response with no read outstanding",
                             test_name(phase), i);
                    count_error();
                end else begin
                    {exp_data, exp_tag} = exp_ring[i][head[i]];
                    head[i] = head[i] + 6'd1;
                    checks++;
                    if (core_rsp_data[i] !== exp_data || core_rsp_tag[i] !== exp_tag) begin
                        $display("ERR %s requester %0d: expected %h tag %h, actual %h tag %h",
                                 test_name(phase), i, exp_data, exp_tag,
                                 core_rsp_data[i], core_rsp_tag[i]);
                        count_error();
                    end
                end
            end
        end
    endtask

    task automatic record_requests();
        for (int i = 0; i < num_requests; i++) begin
            if (core_req_valid[i] && core_req_ready[i]) begin
                if (core_req_write[i]) begin
                    model_mem[core_req_addr[i]] = core_req_data[i];
                end else begin
                    exp_ring[i][tail[i]] = {model_mem[core_req_addr[i]], core_req_tag[i]};
                    tail[i] = tail[i] + 6'd1;
                end
            end
        end
    endtask

    // Accepts of others at the same edge count toward the next interval.
    task automatic check_fairness();
        int accepted;
        accepted = 0;
        for (int i = 0; i < num_requests; i++)
            if (core_req_valid[i] && core_req_ready[i])
                accepted++;
        for (int i = 0; i < num_requests; i++) begin
            if (core_req_valid[i] && core_req_ready[i]) begin
                if (own_count[i] >= warmup && others_since[i] > num_requests - 1) begin
                    $display("Test %s: requester %0d waited through %0d grants to others",
                             test_name(phase), i, others_since[i]);
                    count_error();
                end
                others_since[i] = (own_count[i] < warmup) ? 0 : accepted - 1;
                own_count[i]++;
            end else begin
                others_since[i] += accepted;
            end
        end
    endtask

    task automatic report_end();
        for (int i = 0; i < num_requests; i++) begin
            if (head[i] != tail[i]) begin
                $display("Requester %0d still waits for %0d read responses", i,
                         int'(6'(tail[i] - head[i])));
                count_error();
            end
        end
        $display("Checked %0d responses, %0d errors", checks, errors);
    endtask

    always @(posedge clk) begin
        if (phase != phase_d) begin
            $display("Test %s done: %0d errors", test_name(phase_d), phase_errors);
            phase_errors = 0;
            for (int i = 0; i < num_requests; i++) begin
                own_count[i]    = 0;
                others_since[i] = 0;
            end
            if (phase == 3'd5)
                report_end();
        end
        phase_d = phase;
        if (reset_d && core_rsp_valid !== '0) begin
            $display("Test %s: a response valid is high during or right after reset",
                     test_name(phase));
            count_error();
        end
        reset_d = reset;
        if (!reset) begin
            check_responses();
            record_requests();
            if (phase == 3'd4)
                check_fairness();
        end
        pending = 0;
        for (int i = 0; i < num_requests; i++)
            pending += int'(6'(tail[i] - head[i]));
    end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int num_requests   = 4;
    localparam int read_latency   = 2;
    localparam int clk_period     = 4;
    localparam int total_requests = 200;  // 16 + 60 + 60 + 64.

    logic clk = 1'b0;
    logic reset;
    logic [num_requests-1:0]                                   core_req_valid;
    logic [num_requests-1:0]                                   core_req_write;
    logic [num_requests-1:0][mem_port_pkg::addr_width-1:0]     core_req_addr;
    logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     core_req_data;
    logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] core_req_tag;
    logic [num_requests-1:0]                                   core_req_ready;
    logic [num_requests-1:0]                                   core_rsp_valid;
    logic [num_requests-1:0][mem_port_pkg::line_width-1:0]     core_rsp_data;
    logic [num_requests-1:0][mem_port_pkg::core_tag_width-1:0] core_rsp_tag;
    logic [num_requests-1:0]                                   core_rsp_ready;

    logic [2:0]  phase;
    int          error_count;
    int          pending;
    logic [31:0] rng = 32'd16165;
    int          issue_left [num_requests];
    int          issued [num_requests];
    logic [15:0] written [num_requests];  // Lines already written, per requester.
    int          burst_cycle;

    always #(clk_period / 2) clk = ~clk;

    mem_port_top #(.num_requests(num_requests), .read_latency(read_latency)) dut_i (.*);

    tb_checker #(.num_requests(num_requests)) check_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int requests_left();
        int sum;
        sum = 0;
        for (int i = 0; i < num_requests; i++)
            sum += issue_left[i];
        return sum;
    endfunction

    // A request is only replaced after its transfer.
    task automatic drive_requesters();
        logic [31:0] r;
        logic [31:0] d;
        logic [3:0]  line;
        logic        wr;
        for (int i = 0; i < num_requests; i++) begin
            if (!core_req_valid[i] || core_req_ready[i]) begin
                r = next_random();
                d = next_random();
                if (issue_left[i] > 0 && (phase == 3'd4 || r[1:0] != 2'b00)) begin
                    if (phase == 3'd1) begin
                        wr   = (issued[i] < 8);  // Eight writes, then the same lines read back.
                        line = 4'(issued[i] % 8);
                    end else begin
                        line = r[5:2];
                        wr   = r[6] || !written[i][line];
                    end
                    if (wr)
                        written[i][line] = 1'b1;
                    core_req_valid[i] <= 1'b1;
                    core_req_write[i] <= wr;
                    core_req_addr[i]  <= {2'(i), 2'b00, line};  // Top bits name the requester.
                    core_req_data[i]  <= d;
                    core_req_tag[i]   <= r[10:7];
                    issue_left[i]--;
                    issued[i]++;
                end else begin
                    core_req_valid[i] <= 1'b0;
                end
            end
        end
    endtask

    task automatic drive_rsp_ready();
        logic [31:0] r;
        r = next_random();
        case (phase)
            3'd3: core_rsp_ready <= r[num_requests-1:0];
            3'd4: core_rsp_ready <= (burst_cycle % 16 < 10) ?  // Released in short bursts.
                                    {num_requests{1'b0}} : {num_requests{1'b1}};
            default: core_rsp_ready <= {num_requests{1'b1}};
        endcase
        burst_cycle++;
    endtask

    task automatic step();
        drive_requesters();
        drive_rsp_ready();
    endtask

    task automatic run_phase(input logic [2:0] p, input int per_requester, input logic only_first);
        logic drained;
        phase <= p;
        burst_cycle = 0;
        for (int i = 0; i < num_requests; i++) begin
            issue_left[i] = (only_first && i != 0) ? 0 : per_requester;
            issued[i]     = 0;
        end
        do begin
            @(posedge clk);
            step();
        end while (requests_left() != 0 || core_req_valid != '0);
        drained = 1'b0;
        while (!drained) begin
            @(posedge clk);
            step();
            @(negedge clk);
            drained = (pending == 0 && core_req_valid == '0);
        end
        repeat (10) begin  // Lets queued writes leave.
            @(posedge clk);
            step();
        end
    endtask

    initial begin
        reset          = 1'b1;
        phase          = 3'd0;
        core_req_valid = '0;
        core_req_write = '0;
        core_req_addr  = '0;
        core_req_data  = '0;
        core_req_tag   = '0;
        core_rsp_ready = '1;
        burst_cycle    = 0;
        for (int i = 0; i < num_requests; i++) begin
            issue_left[i] = 0;
            issued[i]     = 0;
            written[i]    = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        run_phase(3'd1, 16, 1'b1);
        run_phase(3'd2, 15, 1'b0);
        run_phase(3'd3, 15, 1'b0);
        run_phase(3'd4, 16, 1'b0);
        phase <= 3'd5;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(total_requests * 40 * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", total_requests * 40);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* verilog.f */
source/mem_port_pkg.sv
source/stream_fifo.sv
source/mem_arb.sv
source/line_mem.sv
source/mem_port_top.sv
tb/tb_checker.sv
tb/tb_top.sv
